//--- hw/crPkg.sv
/*
 shared types for the control-register subsystem
 widths with a meaning, register ids, the pending write carried down
 the pipe and the next-value bundle from the trap unit
 every file refers to these by scoped name
*/
package crPkg;

	// full control register
	typedef logic [63:0] crWord;

	// virtual address, 48 bits
	typedef logic [47:0] crAddr;

	// fpsr, vector mode and trap codes
	typedef logic [15:0] crHalf;

	// register ids, as seen on the write pipe and the read port
	typedef enum logic [6:0]
	{
		CR_PC   = 7'h40,
		CR_LR   = 7'h41,
		CR_SR   = 7'h42,
		CR_VBR  = 7'h43,
		CR_SPC  = 7'h44,
		CR_SSP  = 7'h45,
		CR_GBR  = 7'h46,
		CR_TBR  = 7'h47,
		CR_TTB  = 7'h48,
		CR_TEA  = 7'h49,
		CR_MMCR = 7'h4A,
		CR_EXSR = 7'h4B,
		CR_KRR  = 7'h4D,
		// immediate pseudo register, never stored
		CR_IMM  = 7'h5E,
		// no write / zero register
		CR_ZZR  = 7'h5F
	} crId;

	// one pending register write
	typedef struct packed
	{
		crId   id;
		crWord value;
	} crWrite;

	// default next values offered by the trap unit
	typedef struct packed
	{
		crWord sr;
		crWord exsr;
		crAddr spc;
		crAddr pc;
		crWord tea;
	} crTrapNext;

	// sr bit that marks supervisor mode
	localparam int srSupervisorBit = 30;

	// sr bits 31..0 live in exsr bits 63..32 while in a trap
	localparam int srRestoreBits = 32;

endpackage

//--- hw/crWritebackPipe.sv
/*
 carries control-register writes from EX1 down to writeback
 three stage registers: EX2, EX3 and WB
 a stage whose flush is high hands on a CR_ZZR entry instead
 hold freezes every stage
*/
`timescale 1ns/1ps

module crWritebackPipe
(
	input  logic          clock,
	input  logic          rstN,
	input  logic          hold,
	input  crPkg::crWrite ex1Write,
	input  logic          ex1Flush,
	input  logic          ex2Flush,
	input  logic          ex3Flush,
	output crPkg::crWrite wbWrite
);

	// stage registers
	crPkg::crWrite ex2Stage;
	crPkg::crWrite ex3Stage;
	crPkg::crWrite wbStage;

	// entry as it leaves a stage, killed when that stage is flushed
	function automatic crPkg::crWrite passOn(crPkg::crWrite entry, logic flush);
		crPkg::crWrite result;
		result = entry;
		// only the id is cleared, value is don't-care
		if (flush)
		begin
			result.id = crPkg::CR_ZZR;
		end
		return result;
	endfunction

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			// empty pipe, values left as they are
			ex2Stage.id <= crPkg::CR_ZZR;
			ex3Stage.id <= crPkg::CR_ZZR;
			wbStage.id  <= crPkg::CR_ZZR;
		end
		else if (!hold)
		begin
			// EX1 -> EX2
			ex2Stage <= passOn(ex1Write, ex1Flush);
			// EX2 -> EX3
			ex3Stage <= passOn(ex2Stage, ex2Flush);
			// EX3 -> WB
			wbStage  <= passOn(ex3Stage, ex3Flush);
		end
	end

	// applied by the register file on the next edge
	assign wbWrite = wbStage;

endmodule

//--- hw/crTrapUnit.sv
/*
 trap entry and return-from-trap logic
 offers next values of SR, EXSR, SPC, PC and TEA to the register file
 every cycle, plain pass-through when no strobe is present
 also drives the fetch redirect, one cycle after the strobe edge
*/
`timescale 1ns/1ps

module crTrapUnit
(
	input  logic             clock,
	input  logic             rstN,
	input  logic             hold,
	input  logic             trapReq,
	input  crPkg::crHalf     trapCode,
	input  crPkg::crWord     faultAddr,
	input  logic             rte,
	input  crPkg::crAddr     fetchPc,
	input  crPkg::crWord     curSr,
	input  crPkg::crWord     curExsr,
	input  crPkg::crAddr     curVbr,
	input  crPkg::crAddr     curSpc,
	output crPkg::crTrapNext trapNext,
	output logic             redirectValid,
	output crPkg::crAddr     redirectPc
);

	// strobe accepted this cycle
	logic strobeTaken;

	assign strobeTaken = !hold && (trapReq || rte);

	always_comb
	begin
		// pass-through
		trapNext.sr   = curSr;
		trapNext.exsr = curExsr;
		trapNext.spc  = curSpc;
		trapNext.pc   = fetchPc;
		// only taken by the register file on trap entry
		trapNext.tea  = faultAddr;

		if (trapReq)
		begin
			// enter supervisor mode, upper sr untouched
			trapNext.sr[crPkg::srSupervisorBit] = 1'b1;
			// old sr low half saved high, trap code low
			trapNext.exsr = '0;
			trapNext.exsr[63 -: crPkg::srRestoreBits] = curSr[crPkg::srRestoreBits-1:0];
			trapNext.exsr[15:0] = trapCode;
			// resume point
			trapNext.spc = fetchPc;
		end
		else if (rte)
		begin
			// restore saved low half of sr
			trapNext.sr[crPkg::srRestoreBits-1:0] = curExsr[63 -: crPkg::srRestoreBits];
		end
	end

	// registered redirect
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			redirectValid <= 1'b0;
		end
		else
		begin
			// single cycle pulse, dropped while held
			redirectValid <= strobeTaken;
		end

		if (strobeTaken)
		begin
			// trap wins over rte
			redirectPc <= trapReq ? curVbr : curSpc;
		end
	end

endmodule

//--- hw/controlRegFile.sv
/*
 control registers of the core
 applies the WB entry of the write pipe, otherwise takes the trap
 unit's next values for SR, EXSR, SPC and TEA
 one combinational read port, supervisor-only registers in user mode
 disableTlb ties TTB, MMCR and KRR to zero
*/
`timescale 1ns/1ps

module controlRegFile
#(
	parameter bit disableTlb = 1'b0
)
(
	input  logic             clock,
	input  logic             rstN,
	input  logic             hold,
	input  crPkg::crWrite    wbWrite,
	input  crPkg::crTrapNext trapNext,
	input  crPkg::crAddr     fetchPc,
	input  crPkg::crId       readId,
	output crPkg::crWord     readValue,
	output crPkg::crWord     curSr,
	output crPkg::crWord     curExsr,
	output crPkg::crAddr     curVbr,
	output crPkg::crAddr     curSpc,
	output crPkg::crWord     mmuCtl
);

	// 64-bit registers
	crPkg::crWord srReg;
	crPkg::crWord exsrReg;
	crPkg::crWord lrReg;
	crPkg::crWord teaReg;
	crPkg::crWord ttbReg;
	crPkg::crWord mmcrReg;
	crPkg::crWord krrReg;

	// 48-bit address registers
	crPkg::crAddr spcReg;
	crPkg::crAddr sspReg;
	crPkg::crAddr vbrReg;
	crPkg::crAddr gbrReg;
	crPkg::crAddr tbrReg;

	// 16-bit side fields
	crPkg::crHalf fpsrReg;
	crPkg::crHalf vbrMode;

	// write value split into address part and top field
	crPkg::crAddr wbLow;
	crPkg::crHalf wbHigh;

	logic userMode;
	// supervisor-only writes allowed
	logic privOk;
	logic trapEntry;

	assign wbLow  = wbWrite.value[47:0];
	assign wbHigh = wbWrite.value[63:48];

	// user mode from the current sr only
	assign userMode = !srReg[crPkg::srSupervisorBit];
	assign privOk   = !userMode;

	// trap entry is the only case where the trap unit rewrites exsr
	assign trapEntry = (trapNext.exsr != exsrReg);

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			// start in supervisor mode
			srReg   <= '0;
			srReg[crPkg::srSupervisorBit] <= 1'b1;
			exsrReg <= '0;
			lrReg   <= '0;
			teaReg  <= '0;
			ttbReg  <= '0;
			mmcrReg <= '0;
			krrReg  <= '0;
			spcReg  <= '0;
			sspReg  <= '0;
			vbrReg  <= '0;
			gbrReg  <= '0;
			tbrReg  <= '0;
			fpsrReg <= '0;
			vbrMode <= '0;
		end
		else if (!hold)
		begin
			// sr and exsr always writable, wb beats trap
			srReg   <= (wbWrite.id == crPkg::CR_SR) ? wbWrite.value : trapNext.sr;
			exsrReg <= (wbWrite.id == crPkg::CR_EXSR) ? wbWrite.value : trapNext.exsr;

			// user-writable
			if (wbWrite.id == crPkg::CR_LR)
			begin
				lrReg <= wbWrite.value;
			end
			// gbr carries fpsr in its top 16 bits
			if (wbWrite.id == crPkg::CR_GBR)
			begin
				gbrReg  <= wbLow;
				fpsrReg <= wbHigh;
			end

			// spc and tea also follow the trap unit
			if ((wbWrite.id == crPkg::CR_SPC) && privOk)
				spcReg <= wbLow;
			else
				spcReg <= trapNext.spc;

			if ((wbWrite.id == crPkg::CR_TEA) && privOk)
				teaReg <= wbWrite.value;
			else if (trapEntry)
				teaReg <= trapNext.tea;

			// supervisor only
			if ((wbWrite.id == crPkg::CR_SSP) && privOk)
			begin
				sspReg <= wbLow;
			end
			// vector mode field rides above vbr
			if ((wbWrite.id == crPkg::CR_VBR) && privOk)
			begin
				vbrReg  <= wbLow;
				vbrMode <= wbHigh;
			end
			if ((wbWrite.id == crPkg::CR_TBR) && privOk)
			begin
				tbrReg <= wbLow;
			end

			// mmu registers, left at zero when the tlb is off
			if (!disableTlb && privOk)
			begin
				if (wbWrite.id == crPkg::CR_TTB)
					ttbReg <= wbWrite.value;
				if (wbWrite.id == crPkg::CR_MMCR)
					mmcrReg <= wbWrite.value;
				if (wbWrite.id == crPkg::CR_KRR)
					krrReg <= wbWrite.value;
			end
		end
	end

	// read port
	always_comb
	begin
		case (readId)
			crPkg::CR_SR:   readValue = srReg;
			crPkg::CR_EXSR: readValue = exsrReg;
			// live fetch pc
			crPkg::CR_PC:   readValue = {16'h0000, fetchPc};
			crPkg::CR_LR:   readValue = lrReg;
			crPkg::CR_SPC:  readValue = {16'h0000, spcReg};
			crPkg::CR_SSP:  readValue = {16'h0000, sspReg};
			crPkg::CR_TEA:  readValue = teaReg;
			crPkg::CR_VBR:  readValue = {vbrMode, vbrReg};
			crPkg::CR_GBR:  readValue = {fpsrReg, gbrReg};
			crPkg::CR_TBR:  readValue = {16'h0000, tbrReg};
			crPkg::CR_TTB:  readValue = disableTlb ? '0 : ttbReg;
			crPkg::CR_MMCR: readValue = disableTlb ? '0 : mmcrReg;
			crPkg::CR_KRR:  readValue = disableTlb ? '0 : krrReg;
			// zzr, imm and anything unknown
			default:        readValue = '0;
		endcase
	end

	// to the trap unit
	assign curSr   = srReg;
	assign curExsr = exsrReg;
	assign curVbr  = vbrReg;
	assign curSpc  = spcReg;

	// mmu control out
	assign mmuCtl = disableTlb ? '0 : mmcrReg;

endmodule

//--- hw/crSubsystem.sv
/*
 top level of the control-register subsystem
 write pipe feeds the register file, the trap unit closes the loop
 between the current registers and their next values
 disableTlb is handed to the register file
*/
`timescale 1ns/1ps

module crSubsystem
#(
	parameter bit disableTlb = 1'b0
)
(
	input  logic          clock,
	input  logic          rstN,
	input  crPkg::crWrite ex1Write,
	input  logic          ex1Flush,
	input  logic          ex2Flush,
	input  logic          ex3Flush,
	input  logic          hold,
	input  crPkg::crAddr  fetchPc,
	input  logic          trapReq,
	input  crPkg::crHalf  trapCode,
	input  crPkg::crWord  faultAddr,
	input  logic          rte,
	input  crPkg::crId    readId,
	output crPkg::crWord  readValue,
	output crPkg::crWord  srOut,
	output crPkg::crWord  mmuCtl,
	output logic          redirectValid,
	output crPkg::crAddr  redirectPc
);

	// pipe to register file
	crPkg::crWrite    wbWrite;

	// register file to trap unit and back
	crPkg::crWord     curSr;
	crPkg::crWord     curExsr;
	crPkg::crAddr     curVbr;
	crPkg::crAddr     curSpc;
	crPkg::crTrapNext trapNext;

	crWritebackPipe u_pipe
	(
		.clock    (clock),
		.rstN     (rstN),
		.hold     (hold),
		.ex1Write (ex1Write),
		.ex1Flush (ex1Flush),
		.ex2Flush (ex2Flush),
		.ex3Flush (ex3Flush),
		.wbWrite  (wbWrite)
	);

	crTrapUnit u_trap
	(
		.clock         (clock),
		.rstN          (rstN),
		.hold          (hold),
		.trapReq       (trapReq),
		.trapCode      (trapCode),
		.faultAddr     (faultAddr),
		.rte           (rte),
		.fetchPc       (fetchPc),
		.curSr         (curSr),
		.curExsr       (curExsr),
		.curVbr        (curVbr),
		.curSpc        (curSpc),
		.trapNext      (trapNext),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc)
	);

	controlRegFile #(.disableTlb(disableTlb)) u_regFile
	(
		.clock     (clock),
		.rstN      (rstN),
		.hold      (hold),
		.wbWrite   (wbWrite),
		.trapNext  (trapNext),
		.fetchPc   (fetchPc),
		.readId    (readId),
		.readValue (readValue),
		.curSr     (curSr),
		.curExsr   (curExsr),
		.curVbr    (curVbr),
		.curSpc    (curSpc),
		.mmuCtl    (mmuCtl)
	);

	// current sr straight out
	assign srOut = curSr;

endmodule

//--- tb/crSubsystem_checker.sv
/*
 concurrent checks on the control-register subsystem top level
 bound into every crSubsystem instance, watches the redirect pulse
 and the MMU control value while the core runs in user mode
*/
`timescale 1ns/1ps

module crSubsystem_checker
(
	input logic         clock,
	input logic         rstN,
	input logic         hold,
	input logic         trapReq,
	input logic         rte,
	input crPkg::crWord srOut,
	input crPkg::crWord mmuCtl,
	input logic         redirectValid
);

	// no redirect straight out of reset
	resetQuiet: assert property (@(posedge clock) !rstN |=> !redirectValid)
		else $error("redirect valid in the cycle after reset");

	// pulse lasts one cycle unless a new strobe comes in
	singlePulse: assert property (@(posedge clock) disable iff (!rstN)
		redirectValid && !trapReq && !rte |=> !redirectValid)
		else $error("redirect valid for two cycles without a strobe");

	// accepted trap always redirects on the next cycle
	trapRedirects: assert property (@(posedge clock) disable iff (!rstN)
		trapReq && !hold |=> redirectValid)
		else $error("trap request gave no redirect");

	// user mode cannot touch the mmu control register
	userMmcrStable: assert property (@(posedge clock) disable iff (!rstN)
		!srOut[crPkg::srSupervisorBit] |=> $stable(mmuCtl))
		else $error("mmu control changed in user mode");

endmodule

bind crSubsystem crSubsystem_checker u_checker
(
	.clock         (clock),
	.rstN          (rstN),
	.hold          (hold),
	.trapReq       (trapReq),
	.rte           (rte),
	.srOut         (srOut),
	.mmuCtl        (mmuCtl),
	.redirectValid (redirectValid)
);

//--- tb/crSubsystem_tb.sv
/*
 directed testbench for the control-register subsystem
 drives the write pipe, flushes, hold and the trap strobes, and keeps
 a model of the registers that every read is compared with
 the first mismatch ends the run, a watchdog bounds it
*/
`timescale 1ns/1ps

module crSubsystem_tb;

	localparam int clockPeriod = 100;
	// reset, then each test in the order they run
	localparam int testCycles = 4 + 18 + 39 + 24 + 18 + 47 + 51;
	localparam int marginCycles = 100;

	localparam crPkg::crWrite idleWrite = '{id: crPkg::CR_ZZR, value: '0};

	// ids read back in every full sweep
	localparam crPkg::crId allIds [14] = '{
		crPkg::CR_SR, crPkg::CR_EXSR, crPkg::CR_LR, crPkg::CR_SPC, crPkg::CR_SSP,
		crPkg::CR_TEA, crPkg::CR_VBR, crPkg::CR_GBR, crPkg::CR_TBR, crPkg::CR_TTB,
		crPkg::CR_MMCR, crPkg::CR_KRR, crPkg::CR_IMM, crPkg::CR_ZZR
	};

	logic          clock = 1'b0;
	logic          rstN;
	crPkg::crWrite ex1Write;
	logic          ex1Flush;
	logic          ex2Flush;
	logic          ex3Flush;
	logic          hold;
	crPkg::crAddr  fetchPc;
	logic          trapReq;
	crPkg::crHalf  trapCode;
	crPkg::crWord  faultAddr;
	logic          rte;
	crPkg::crId    readId;
	crPkg::crWord  readValue;
	crPkg::crWord  srOut;
	crPkg::crWord  mmuCtl;
	logic          redirectValid;
	crPkg::crAddr  redirectPc;

	// expected read value per register id
	crPkg::crWord model [128];

	crSubsystem #(.disableTlb(1'b0)) u_dut
	(
		.clock         (clock),
		.rstN          (rstN),
		.ex1Write      (ex1Write),
		.ex1Flush      (ex1Flush),
		.ex2Flush      (ex2Flush),
		.ex3Flush      (ex3Flush),
		.hold          (hold),
		.fetchPc       (fetchPc),
		.trapReq       (trapReq),
		.trapCode      (trapCode),
		.faultAddr     (faultAddr),
		.rte           (rte),
		.readId        (readId),
		.readValue     (readValue),
		.srOut         (srOut),
		.mmuCtl        (mmuCtl),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc)
	);

	always #(clockPeriod / 2) clock = ~clock;

	function automatic crPkg::crWord randomWord();
		return {$urandom, $urandom};
	endfunction

	// value as it reads back after a write
	function automatic crPkg::crWord storedForm(crPkg::crId id, crPkg::crWord value);
		case (id)
			// 48-bit registers read zero-extended
			crPkg::CR_SPC, crPkg::CR_SSP, crPkg::CR_TBR: return {16'h0000, value[47:0]};
			crPkg::CR_IMM, crPkg::CR_ZZR: return '0;
			// vbr and gbr keep their top field, the rest are full width
			default: return value;
		endcase
	endfunction

	// registers that only supervisor mode may write
	function automatic logic supervisorOnly(crPkg::crId id);
		case (id)
			crPkg::CR_SPC, crPkg::CR_SSP, crPkg::CR_TEA, crPkg::CR_VBR,
			crPkg::CR_TBR, crPkg::CR_TTB, crPkg::CR_MMCR, crPkg::CR_KRR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// a write landing now, dropped in user mode where protected
	function automatic void modelWrite(crPkg::crId id, crPkg::crWord value);
		if (!(supervisorOnly(id) && !model[crPkg::CR_SR][crPkg::srSupervisorBit]))
		begin
			model[id] = storedForm(id, value);
		end
	endfunction

	task automatic checkValue(
		input crPkg::crWord actual,
		input crPkg::crWord expected,
		input string what
	);
		if (actual !== expected)
		begin
			$display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "first mismatch ends the run");
		end
	endtask

	// one cycle: select the id, sample mid-cycle
	task automatic readCheck(
		input crPkg::crId id,
		input crPkg::crWord expected,
		input string what
	);
		@(posedge clock);
		readId <= id;
		@(negedge clock);
		checkValue(readValue, expected, what);
	endtask

	task automatic checkAll(input string when);
		foreach (allIds[i])
		begin
			readCheck(allIds[i], model[allIds[i]], $sformatf("%s, id %h", when, allIds[i]));
		end
		// live fetch pc and an id outside the register set
		readCheck(crPkg::CR_PC, {16'h0000, fetchPc}, {when, ", pc"});
		readCheck(crPkg::crId'(7'h00), 64'h0, {when, ", unknown id"});
		checkValue(srOut, model[crPkg::CR_SR], {when, ", srOut"});
		checkValue(mmuCtl, model[crPkg::CR_MMCR], {when, ", mmuCtl"});
	endtask

	// present a write in EX1 and wait until it is applied
	task automatic landWrite(input crPkg::crId id, input crPkg::crWord value);
		@(posedge clock);
		ex1Write <= '{id, value};
		@(posedge clock);
		ex1Write <= idleWrite;
		// EX3, WB, then the write itself
		repeat (3) @(posedge clock);
		modelWrite(id, value);
	endtask

	task automatic resetState();
		@(negedge clock);
		checkValue(64'(redirectValid), 64'h0, "redirect after reset");
		checkAll("reset");
	endtask

	task automatic writePipelining();
		crPkg::crId ids [4];
		crPkg::crWord vals [4];
		crPkg::crWord oldLr;
		ids = '{crPkg::CR_LR, crPkg::CR_GBR, crPkg::CR_VBR, crPkg::CR_MMCR};
		oldLr = model[crPkg::CR_LR];
		foreach (vals[k])
		begin
			vals[k] = randomWord();
		end
		// back to back, lr must not show before its fourth edge
		foreach (ids[k])
		begin
			@(posedge clock);
			ex1Write <= '{ids[k], vals[k]};
			readId <= crPkg::CR_LR;
			@(negedge clock);
			checkValue(readValue, oldLr, "lr before its fourth edge");
		end
		// each lands one cycle after the one before
		foreach (ids[k])
		begin
			@(posedge clock);
			ex1Write <= idleWrite;
			readId <= ids[k];
			@(negedge clock);
			// gbr and vbr compare fpsr and vector mode in the top 16 bits too
			checkValue(readValue, storedForm(ids[k], vals[k]), "write after its fourth edge");
			modelWrite(ids[k], vals[k]);
		end
		// upper bits of these are random and must read back as zero
		landWrite(crPkg::CR_SPC, randomWord());
		landWrite(crPkg::CR_SSP, randomWord());
		landWrite(crPkg::CR_TBR, randomWord());
		checkAll("48-bit registers");
	endtask

	task automatic flushStages();
		crPkg::crWord value;
		for (int stage = 1; stage <= 3; stage++)
		begin
			value = randomWord();
			@(posedge clock);
			ex1Write <= '{crPkg::CR_LR, value};
			ex1Flush <= (stage == 1);
			@(posedge clock);
			ex1Write <= idleWrite;
			ex1Flush <= 1'b0;
			ex2Flush <= (stage == 2);
			@(posedge clock);
			ex2Flush <= 1'b0;
			ex3Flush <= (stage == 3);
			@(posedge clock);
			ex3Flush <= 1'b0;
			// edge where it would have landed
			@(posedge clock);
			readCheck(crPkg::CR_LR, model[crPkg::CR_LR], $sformatf("lr flushed in EX%0d", stage));
		end
		landWrite(crPkg::CR_LR, randomWord());
		readCheck(crPkg::CR_LR, model[crPkg::CR_LR], "unflushed lr write");
	endtask

	task automatic holdDelay(input int holdCycles);
		crPkg::crWord value;
		crPkg::crWord oldLr;
		value = randomWord();
		oldLr = model[crPkg::CR_LR];
		@(posedge clock);
		ex1Write <= '{crPkg::CR_LR, value};
		readId <= crPkg::CR_LR;
		// write now in EX2, frozen there
		@(posedge clock);
		ex1Write <= idleWrite;
		hold <= 1'b1;
		repeat (holdCycles)
		begin
			@(negedge clock);
			checkValue(readValue, oldLr, "lr while held");
			@(posedge clock);
		end
		hold <= 1'b0;
		// EX3, WB and the write, each one edge late by the hold
		repeat (3)
		begin
			@(negedge clock);
			checkValue(readValue, oldLr, "lr before delayed landing");
			@(posedge clock);
		end
		@(negedge clock);
		checkValue(readValue, value, "lr landing after hold");
		modelWrite(crPkg::CR_LR, value);
	endtask

	task automatic trapAndReturn();
		crPkg::crWord srOrig;
		crPkg::crWord srMid;
		crPkg::crAddr pcVal;
		crPkg::crHalf code;
		crPkg::crWord fault;
		srOrig = randomWord();
		// trap taken from user mode, so entry has to set the supervisor bit
		srOrig[crPkg::srSupervisorBit] = 1'b0;
		landWrite(crPkg::CR_SR, srOrig);
		pcVal = 48'(randomWord());
		// nonzero so exsr is sure to change
		code = 16'($urandom) | 16'h0001;
		fault = randomWord();
		@(posedge clock);
		fetchPc <= pcVal;
		trapCode <= code;
		faultAddr <= fault;
		trapReq <= 1'b1;
		@(posedge clock);
		trapReq <= 1'b0;
		@(negedge clock);
		checkValue(64'(redirectValid), 64'h1, "redirect after trap");
		checkValue({16'h0000, redirectPc}, {16'h0000, model[crPkg::CR_VBR][47:0]}, "trap target");
		// old sr low half saved high, code low, supervisor forced
		model[crPkg::CR_EXSR] = {srOrig[31:0], 16'h0000, code};
		model[crPkg::CR_SR][crPkg::srSupervisorBit] = 1'b1;
		model[crPkg::CR_SPC] = {16'h0000, pcVal};
		model[crPkg::CR_TEA] = fault;
		@(posedge clock);
		fetchPc <= 48'(randomWord());
		@(negedge clock);
		checkValue(64'(redirectValid), 64'h0, "redirect is a single pulse");
		checkAll("after trap");
		// change sr so the restore is visible
		srMid = randomWord();
		srMid[crPkg::srSupervisorBit] = 1'b1;
		landWrite(crPkg::CR_SR, srMid);
		@(posedge clock);
		rte <= 1'b1;
		@(posedge clock);
		rte <= 1'b0;
		@(negedge clock);
		checkValue(64'(redirectValid), 64'h1, "redirect after rte");
		checkValue({16'h0000, redirectPc}, model[crPkg::CR_SPC], "rte target");
		model[crPkg::CR_SR] = {srMid[63:32], model[crPkg::CR_EXSR][63:32]};
		checkAll("after rte");
	endtask

	task automatic userProtection();
		crPkg::crWord srUser;
		crPkg::crId dropped [4];
		crPkg::crId kept [2];
		dropped = '{crPkg::CR_VBR, crPkg::CR_TBR, crPkg::CR_MMCR, crPkg::CR_SPC};
		kept = '{crPkg::CR_LR, crPkg::CR_GBR};
		srUser = randomWord();
		srUser[crPkg::srSupervisorBit] = 1'b0;
		landWrite(crPkg::CR_SR, srUser);
		// model drops these, dut must too
		foreach (dropped[k])
		begin
			landWrite(dropped[k], randomWord());
		end
		foreach (kept[k])
		begin
			landWrite(kept[k], randomWord());
		end
		checkAll("user mode");
	endtask

	initial
	begin
		void'($urandom(86));
		foreach (model[i])
		begin
			model[i] = '0;
		end
		model[crPkg::CR_SR][crPkg::srSupervisorBit] = 1'b1;
		rstN <= 1'b0;
		ex1Write <= idleWrite;
		ex1Flush <= 1'b0;
		ex2Flush <= 1'b0;
		ex3Flush <= 1'b0;
		hold <= 1'b0;
		fetchPc <= '0;
		trapReq <= 1'b0;
		trapCode <= '0;
		faultAddr <= '0;
		rte <= 1'b0;
		readId <= crPkg::CR_ZZR;
		repeat (4) @(posedge clock);
		rstN <= 1'b1;
		fetchPc <= 48'(randomWord());
		resetState();
		writePipelining();
		flushStages();
		holdDelay(1);
		holdDelay(5);
		trapAndReturn();
		userProtection();
		@(posedge clock);
		$display("NO ERRORS");
		$finish;
	end

	// watchdog
	initial
	begin
		#(clockPeriod * (testCycles + marginCycles));
		$display("timeout: tests still running after %0d cycles", testCycles + marginCycles);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- files.f
hw/crPkg.sv
hw/crWritebackPipe.sv
hw/crTrapUnit.sv
hw/controlRegFile.sv
hw/crSubsystem.sv
tb/crSubsystem_checker.sv
tb/crSubsystem_tb.sv

//--- Makefile
# Verilator build for the control-register subsystem
# lint checks the sources, sim builds and runs the testbench,
# the run's exit status is the test result

TOP := crSubsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o crSim
	./obj_dir/crSim

clean:
	rm -rf obj_dir
